// File: source/pc_config_pkg.sv
`default_nettype none

package pc_config_pkg;

  ////////////////////////////////////////////////////////////
  // word and field widths

  localparam int pc_word_w = 32;
  localparam int conf_w = 16;
  localparam int leaf_w = 6;
  localparam int bd_payload_w = 24;
  localparam int id_w = 6;

  // default array sizes, overridden from the top level
  localparam int default_nreg = 64;
  localparam int default_nchan = 2;
  localparam int default_ndeser = 2;

  ////////////////////////////////////////////////////////////
  // input word layouts

  // fpga-bound word
  // [ 1 | reg_or_chan | array_id | unused | data ]
  // same layout for register and channel words
  typedef struct packed {
    logic fpga_or_bd;
    logic reg_or_chan;
    logic [id_w-1:0] array_id;
    logic [7:0] unused;
    logic [conf_w-1:0] data;
  } fpga_word_t;

  // bd-bound word
  // [ 00 | leaf_code | payload ]
  // top bit low marks a bd word
  typedef struct packed {
    logic [1:0] unused;
    logic [leaf_w-1:0] leaf_code;
    logic [bd_payload_w-1:0] payload;
  } bd_word_t;

  // one pc word seen either way
  typedef union packed {
    fpga_word_t fpga;
    bd_word_t bd;
  } pc_word_u;

  ////////////////////////////////////////////////////////////
  // channels

  // input word from the host link, ack runs back separately
  typedef struct packed {
    logic valid;
    logic [pc_word_w-1:0] word;
  } pc_in_t;

  // passthrough toward the bd side
  typedef struct packed {
    logic valid;
    logic [leaf_w-1:0] leaf_code;
    logic [bd_payload_w-1:0] payload;
  } bd_out_t;

  // what an input word is for
  typedef enum logic [1:0] {
    bd_word,
    reg_word,
    chan_word
  } word_kind_e;

endpackage

`default_nettype wire

// File: source/pc_word_parser.sv
`timescale 1ns/10ps
`default_nettype none

module pc_word_parser
  import pc_config_pkg::*;
#(
  parameter int Nreg = default_nreg,
  parameter int Nchan = default_nchan
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic stall,
  input wire pc_in_t pc_in,
  input wire logic [Nreg-1:0][conf_w-1:0] conf_reg_reset_vals,
  input wire logic bd_ack,
  input wire logic [Nchan-1:0] chan_a,
  output logic pc_ack,
  output logic [Nreg-1:0][conf_w-1:0] conf_regs,
  output bd_out_t bd_out,
  output logic [Nchan-1:0] chan_v,
  output logic [Nchan-1:0][conf_w-1:0] chan_d
);

  // select widths, ids only use their low bits
  localparam int reg_sel_w = (Nreg > 1) ? $clog2(Nreg) : 1;
  localparam int chan_sel_w = (Nchan > 1) ? $clog2(Nchan) : 1;

  pc_word_u word_u;
  word_kind_e kind;
  logic in_v;
  logic reg_write;
  logic [reg_sel_w-1:0] reg_sel;
  logic [chan_sel_w-1:0] chan_sel;

  ////////////////////////////////////////////////////////////
  // input side

  // stall from the traffic manager masks the input valid
  assign in_v = pc_in.valid && !stall;

  // same word read as fpga word or as bd word
  assign word_u = pc_in.word;

  // array id truncated to the array size, larger ids wrap
  assign reg_sel = word_u.fpga.array_id[reg_sel_w-1:0];
  assign chan_sel = word_u.fpga.array_id[chan_sel_w-1:0];

  // classify by the two top bits
  always_comb begin
    if (!word_u.fpga.fpga_or_bd) begin
      kind = bd_word;
    end else if (!word_u.fpga.reg_or_chan) begin
      kind = reg_word;
    end else begin
      kind = chan_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // configuration registers

  // register words never wait, so a valid one is taken at once
  assign reg_write = in_v && (kind == reg_word);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      // reset values come from the mapper
      conf_regs <= conf_reg_reset_vals;
    end else if (reg_write) begin
      conf_regs[reg_sel] <= word_u.fpga.data;
    end
  end

  ////////////////////////////////////////////////////////////
  // bd passthrough and channel routing

  // bd fields go straight out, valid only for a bd word
  always_comb begin
    bd_out.valid = in_v && (kind == bd_word);
    bd_out.leaf_code = word_u.bd.leaf_code;
    bd_out.payload = word_u.bd.payload;
  end

  // data fans out to every channel
  // only the addressed one sees valid
  always_comb begin
    for (int i = 0; i < Nchan; i++) begin
      chan_v[i] = in_v && (kind == chan_word) && (chan_sel == chan_sel_w'(i));
      chan_d[i] = word_u.fpga.data;
    end
  end

  // ack comes from whichever destination the word is headed for
  always_comb begin
    pc_ack = 1'b0;
    if (in_v) begin
      case (kind)
        bd_word: pc_ack = bd_ack;
        reg_word: pc_ack = 1'b1;
        chan_word: pc_ack = chan_a[chan_sel];
        default: pc_ack = 1'b0;
      endcase
    end
  end

  // at most one channel addressed per word
  a_chan_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(chan_v))
    else $error("chan_v not one-hot: %b", chan_v);

  // a stalled word must not be taken
  a_stall_no_ack: assert property (@(posedge clk) disable iff (reset) stall |-> !pc_ack)
    else $error("pc_ack high during stall");

endmodule

`default_nettype wire

// File: source/conf_chan_deserializer.sv
`timescale 1ns/10ps
`default_nettype none

module conf_chan_deserializer
  import pc_config_pkg::*;
#(
  parameter int Ndeser = default_ndeser
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic piece_v,
  input wire logic [conf_w-1:0] piece_d,
  output logic piece_a,
  output logic item_v,
  output logic [conf_w*Ndeser-1:0] item_d,
  input wire logic item_a
);

  localparam int item_w = conf_w * Ndeser;
  localparam int cnt_w = (Ndeser > 1) ? $clog2(Ndeser) : 1;

  // pieces already in the accumulator
  logic [cnt_w-1:0] cnt;
  logic last_piece;
  logic piece_fire;
  logic [item_w-1:0] acc;
  logic [item_w-1:0] shifted;

  // shift accumulator needs at least two pieces
  if (Ndeser < 2) begin : g_size_check
    $error("conf_chan_deserializer needs Ndeser of at least 2");
  end

  ////////////////////////////////////////////////////////////
  // accumulator

  // new piece enters at the top, first piece ends up lowest
  assign shifted = {piece_d, acc[item_w-1:conf_w]};
  assign last_piece = (cnt == cnt_w'(Ndeser - 1));

  // only the final piece waits for a free output register
  assign piece_a = !(last_piece && item_v);
  assign piece_fire = piece_v && piece_a;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt <= '0;
    end else if (piece_fire) begin
      cnt <= last_piece ? '0 : cnt + 1'b1;
    end
  end

  // payload only, old contents get shifted out
  always_ff @(posedge clk) begin
    if (piece_fire) begin
      acc <= shifted;
    end
  end

  ////////////////////////////////////////////////////////////
  // output holding register

  // completed word moves over as the last piece arrives
  always_ff @(posedge clk) begin
    if (piece_fire && last_piece) begin
      item_d <= shifted;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      item_v <= 1'b0;
    end else if (piece_fire && last_piece) begin
      item_v <= 1'b1;
    end else if (item_a) begin
      item_v <= 1'b0;
    end
  end

  // item held until the arbiter takes it
  a_item_hold: assert property (@(posedge clk) disable iff (reset)
    item_v && !item_a |=> item_v && $stable(item_d))
    else $error("item_d changed before ack");

endmodule

`default_nettype wire

// File: source/conf_chan_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module conf_chan_arbiter
  import pc_config_pkg::*;
#(
  parameter int Nchan = default_nchan,
  parameter int Ndeser = default_ndeser,
  localparam int cid_w = (Nchan > 1) ? $clog2(Nchan) : 1,
  localparam int item_w = conf_w * Ndeser,
  localparam type out_item_t = struct packed {
    logic [cid_w-1:0] chan_id;
    logic [item_w-1:0] data;
  }
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic [Nchan-1:0] item_v,
  input wire logic [Nchan-1:0][item_w-1:0] item_d,
  output logic [Nchan-1:0] item_a,
  output logic out_v,
  output out_item_t out_item,
  input wire logic out_ack
);

  // first channel looked at in the next search
  logic [cid_w-1:0] ptr;
  logic [cid_w-1:0] pick;
  logic found;
  logic load;

  // output register free now or freed this cycle
  assign load = !out_v || out_ack;

  ////////////////////////////////////////////////////////////
  // round-robin search

  always_comb begin
    int idx;
    found = 1'b0;
    pick = ptr;
    for (int k = 0; k < Nchan; k++) begin
      // wrap around the channel count
      idx = int'(ptr) + k;
      if (idx >= Nchan) begin
        idx = idx - Nchan;
      end
      if (!found && item_v[idx]) begin
        found = 1'b1;
        pick = cid_w'(idx);
      end
    end
  end

  // grant acks the chosen deserializer right away
  always_comb begin
    item_a = '0;
    if (load && found) begin
      item_a[pick] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // output register

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_v <= 1'b0;
      ptr <= '0;
    end else if (load) begin
      out_v <= found;
      // move past the served channel
      if (found) begin
        ptr <= (pick == cid_w'(Nchan - 1)) ? '0 : pick + 1'b1;
      end
    end
  end

  // tag the item with its channel
  always_ff @(posedge clk) begin
    if (load && found) begin
      out_item.chan_id <= pick;
      out_item.data <= item_d[pick];
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(item_a))
    else $error("item_a not one-hot: %b", item_a);

endmodule

`default_nettype wire

// File: source/pc_config_top.sv
`timescale 1ns/10ps
`default_nettype none

module pc_config_top
  import pc_config_pkg::*;
#(
  parameter int Nreg = default_nreg,
  parameter int Nchan = default_nchan,
  parameter int Ndeser = default_ndeser,
  localparam int cid_w = (Nchan > 1) ? $clog2(Nchan) : 1,
  localparam int item_w = conf_w * Ndeser,
  localparam type out_item_t = struct packed {
    logic [cid_w-1:0] chan_id;
    logic [item_w-1:0] data;
  }
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic stall,
  input wire pc_in_t pc_in,
  input wire logic [Nreg-1:0][conf_w-1:0] conf_reg_reset_vals,
  input wire logic bd_ack,
  input wire logic out_ack,
  output logic pc_ack,
  output logic [Nreg-1:0][conf_w-1:0] conf_regs,
  output bd_out_t bd_out,
  output logic out_v,
  output out_item_t out_item
);

  // parser to deserializers
  wire logic [Nchan-1:0] chan_v;
  wire logic [Nchan-1:0][conf_w-1:0] chan_d;
  wire logic [Nchan-1:0] chan_a;

  // deserializers to arbiter
  wire logic [Nchan-1:0] item_v;
  wire logic [Nchan-1:0][item_w-1:0] item_d;
  wire logic [Nchan-1:0] item_a;

  ////////////////////////////////////////////////////////////
  // word parser

  pc_word_parser #(
    .Nreg(Nreg),
    .Nchan(Nchan)
  ) parser_i (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .pc_in(pc_in),
    .conf_reg_reset_vals(conf_reg_reset_vals),
    .bd_ack(bd_ack),
    .chan_a(chan_a),
    .pc_ack(pc_ack),
    .conf_regs(conf_regs),
    .bd_out(bd_out),
    .chan_v(chan_v),
    .chan_d(chan_d)
  );

  ////////////////////////////////////////////////////////////
  // one deserializer per channel

  for (genvar i = 0; i < Nchan; i++) begin : g_deser
    conf_chan_deserializer #(
      .Ndeser(Ndeser)
    ) deser_i (
      .clk(clk),
      .reset(reset),
      .piece_v(chan_v[i]),
      .piece_d(chan_d[i]),
      .piece_a(chan_a[i]),
      .item_v(item_v[i]),
      .item_d(item_d[i]),
      .item_a(item_a[i])
    );
  end

  ////////////////////////////////////////////////////////////
  // merge into the tagged output stream

  conf_chan_arbiter #(
    .Nchan(Nchan),
    .Ndeser(Ndeser)
  ) arbiter_i (
    .clk(clk),
    .reset(reset),
    .item_v(item_v),
    .item_d(item_d),
    .item_a(item_a),
    .out_v(out_v),
    .out_item(out_item),
    .out_ack(out_ack)
  );

endmodule

`default_nettype wire

// File: test/pc_config_checks.sv
`timescale 1ns/10ps
`default_nettype none

module pc_config_checks
  import pc_config_pkg::*;
#(
  parameter int Nreg = default_nreg,
  parameter int Nchan = default_nchan,
  parameter int Ndeser = default_ndeser,
  localparam int cid_w = (Nchan > 1) ? $clog2(Nchan) : 1,
  localparam int item_w = conf_w * Ndeser
) (
  input wire logic clk,
  input wire logic reset,
  input wire logic stall,
  input wire pc_in_t pc_in,
  input wire logic pc_ack,
  input wire logic [Nreg-1:0][conf_w-1:0] conf_reg_reset_vals,
  input wire logic [Nreg-1:0][conf_w-1:0] conf_regs,
  input wire bd_out_t bd_out,
  input wire logic bd_ack,
  input wire logic out_v,
  input wire logic [cid_w-1:0] out_chan,
  input wire logic [item_w-1:0] out_data,
  input wire logic out_ack,
  output int err_cnt
);

  localparam int reg_sel_w = (Nreg > 1) ? $clog2(Nreg) : 1;
  localparam int bd_w = leaf_w + bd_payload_w;

  ////////////////////////////////////////////////////////////
  // reference model

  logic [Nreg-1:0][conf_w-1:0] exp_regs;
  logic [bd_w-1:0] bd_q[$];
  logic [item_w-1:0] item_q[Nchan][$];
  // item still being gathered, per channel
  logic [item_w-1:0] partial[Nchan];
  int fill[Nchan] = '{default: 0};
  // queue fronts
  logic [bd_w-1:0] bd_head = '0;
  logic bd_none = 1'b1;
  logic [item_w-1:0] item_head[Nchan] = '{default: '0};
  logic [Nchan-1:0] item_none = '1;
  int errors = 0;
  logic [pc_word_w-1:0] w;
  logic reg_take;

  assign err_cnt = errors;
  assign w = pc_in.word;
  // register words are taken whenever valid and not stalled
  assign reg_take = pc_in.valid && !stall && w[31] && !w[30];

  function automatic void refresh_heads();
    bd_none = (bd_q.size() == 0);
    bd_head = bd_none ? '0 : bd_q[0];
    for (int c = 0; c < Nchan; c++) begin
      item_none[c] = (item_q[c].size() == 0);
      item_head[c] = item_none[c] ? '0 : item_q[c][0];
    end
  endfunction

  // called by the stimulus as a word is first offered
  task automatic expect_word(input logic [pc_word_w-1:0] word);
    int c;
    c = int'(word[24 +: cid_w]);
    if (!word[31]) begin
      bd_q.push_back(word[bd_w-1:0]);
    end else if (word[30]) begin
      // lowest piece first
      partial[c][conf_w*fill[c] +: conf_w] = word[conf_w-1:0];
      fill[c]++;
      if (fill[c] == Ndeser) begin
        item_q[c].push_back(partial[c]);
        fill[c] = 0;
      end
    end
    refresh_heads();
  endtask

  // words still owed by the DUT
  function automatic int remaining();
    int n;
    n = bd_q.size();
    for (int c = 0; c < Nchan; c++) begin
      n += item_q[c].size();
    end
    return n;
  endfunction

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      exp_regs <= conf_reg_reset_vals;
    end else begin
      if (reg_take) begin
        exp_regs[w[24 +: reg_sel_w]] <= w[conf_w-1:0];
      end
      if (bd_out.valid && bd_ack && bd_q.size() > 0) begin
        void'(bd_q.pop_front());
      end
      if (out_v && out_ack && item_q[out_chan].size() > 0) begin
        void'(item_q[out_chan].pop_front());
      end
      refresh_heads();
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions

  a_reset_quiet: assert property (@(posedge clk)
    $fell(reset) |-> !bd_out.valid && !out_v && !pc_ack)
    else begin
      errors++;
      $display("error at %0t: an output valid is high right after reset", $time);
    end

  // stalled words are neither acked nor passed on
  a_stall_hold: assert property (@(posedge clk) disable iff (reset)
    stall |-> !pc_ack && !bd_out.valid)
    else begin
      errors++;
      $display("error at %0t: a word was taken while stall was high", $time);
    end

  a_reg_ack: assert property (@(posedge clk) disable iff (reset) reg_take |-> pc_ack)
    else begin
      errors++;
      $display("error at %0t: pc_ack expected 1 actual %b", $time, $sampled(pc_ack));
    end

  for (genvar r = 0; r < Nreg; r++) begin : g_reg_chk
    a_reg_value: assert property (@(posedge clk) disable iff (reset)
      conf_regs[r] == exp_regs[r])
      else begin
        errors++;
        $display("error at %0t: conf_regs[%0d] expected %h actual %h", $time, r,
          $sampled(exp_regs[r]), $sampled(conf_regs[r]));
      end
  end

  a_bd_word: assert property (@(posedge clk) disable iff (reset)
    bd_out.valid && bd_ack |-> !bd_none && {bd_out.leaf_code, bd_out.payload} == bd_head)
    else begin
      errors++;
      $display("error at %0t: bd_out expected %h actual %h (none expected: %b)", $time,
        $sampled(bd_head), $sampled({bd_out.leaf_code, bd_out.payload}), $sampled(bd_none));
    end

  // each channel in its own order
  a_out_item: assert property (@(posedge clk) disable iff (reset)
    out_v && out_ack |-> !item_none[out_chan] && out_data == item_head[out_chan])
    else begin
      errors++;
      $display("error at %0t: out_item.data chan %0d expected %h actual %h", $time,
        $sampled(out_chan), $sampled(item_head[out_chan]), $sampled(out_data));
    end

endmodule

`default_nettype wire

// File: test/pc_config_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pc_config_tb
  import pc_config_pkg::*;
();

  localparam int nreg = default_nreg;
  localparam int nchan = default_nchan;
  localparam int ndeser = default_ndeser;
  localparam int cid_w = (nchan > 1) ? $clog2(nchan) : 1;
  localparam int item_w = conf_w * ndeser;
  localparam int clk_period = 8;
  localparam int reset_cycles = 16;

  // words per test, the channel test tops up partial items
  localparam int reg_words = 40;
  localparam int bd_words = 40;
  localparam int chan_words = 40 + nchan * ndeser;
  localparam int stall_words = 2 + ndeser;
  localparam int total_words = reg_words + bd_words + chan_words + stall_words;
  localparam int limit_cycles = reset_cycles + total_words * 40;

  // same layout as the tagged output item
  typedef struct packed {
    logic [cid_w-1:0] chan_id;
    logic [item_w-1:0] data;
  } out_item_t;

  logic clk;
  logic reset;
  logic stall;
  pc_in_t pc_in;
  logic [nreg-1:0][conf_w-1:0] conf_reg_reset_vals;
  logic bd_ack;
  logic out_ack;
  logic pc_ack;
  logic [nreg-1:0][conf_w-1:0] conf_regs;
  bd_out_t bd_out;
  logic out_v;
  out_item_t out_item;
  int err_cnt;
  int err_mark = 0;
  int tests_run = 0;

  pc_config_top dut_i (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .pc_in(pc_in),
    .conf_reg_reset_vals(conf_reg_reset_vals),
    .bd_ack(bd_ack),
    .out_ack(out_ack),
    .pc_ack(pc_ack),
    .conf_regs(conf_regs),
    .bd_out(bd_out),
    .out_v(out_v),
    .out_item(out_item)
  );

  pc_config_checks checks_i (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .pc_in(pc_in),
    .pc_ack(pc_ack),
    .conf_reg_reset_vals(conf_reg_reset_vals),
    .conf_regs(conf_regs),
    .bd_out(bd_out),
    .bd_ack(bd_ack),
    .out_v(out_v),
    .out_chan(out_item.chan_id),
    .out_data(out_item.data),
    .out_ack(out_ack),
    .err_cnt(err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(limit_cycles * clk_period);
    $display("timeout: run went past %0d cycles with words still owed", limit_cycles);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers

  function automatic logic [pc_word_w-1:0] build_reg_word(int idx, logic [conf_w-1:0] d);
    return {2'b10, id_w'(idx), 8'h00, d};
  endfunction

  function automatic logic [pc_word_w-1:0] build_chan_word(int ch, logic [conf_w-1:0] d);
    return {2'b11, id_w'(ch), 8'h00, d};
  endfunction

  function automatic logic [pc_word_w-1:0] build_bd_word(logic [leaf_w-1:0] leaf,
                                                         logic [bd_payload_w-1:0] payload);
    return {2'b00, leaf, payload};
  endfunction

  // called on a falling edge, returns on the falling edge after the ack
  task automatic send_word(input logic [pc_word_w-1:0] word, input int stall_cycles);
    checks_i.expect_word(word);
    pc_in.valid = 1'b1;
    pc_in.word = word;
    if (stall_cycles > 0) begin
      stall = 1'b1;
      repeat (stall_cycles) @(negedge clk);
      stall = 1'b0;
    end
    do begin
      @(posedge clk);
    end while (!pc_ack);
    @(negedge clk);
    pc_in.valid = 1'b0;
  endtask

  task automatic drive_backpressure();
    forever begin
      @(negedge clk);
      bd_ack = ($urandom % 4) != 0;
      out_ack = ($urandom % 2) != 0;
    end
  endtask

  task automatic drain_outputs();
    while (checks_i.remaining() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name, input int words);
    $display("test %s done: %0d words, %0d errors", name, words, err_cnt - err_mark);
    err_mark = err_cnt;
    tests_run++;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    int sent[nchan];
    int c;
    int n;
    void'($urandom(32'h4b960337));
    reset = 1'b1;
    stall = 1'b0;
    pc_in = '0;
    bd_ack = 1'b0;
    out_ack = 1'b0;
    for (int r = 0; r < nreg; r++) begin
      // pattern depends on every index bit
      conf_reg_reset_vals[r] = {4'hc, r[5:0], ~r[5:0]};
    end
    fork
      drive_backpressure();
    join_none
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    finish_test("reset", 0);

    for (int k = 0; k < reg_words; k++) begin
      send_word(build_reg_word($urandom % nreg, conf_w'($urandom)), 0);
    end
    @(negedge clk);
    finish_test("registers", reg_words);

    for (int k = 0; k < bd_words; k++) begin
      send_word(build_bd_word(leaf_w'($urandom), bd_payload_w'($urandom)), 0);
    end
    @(negedge clk);
    finish_test("bd passthrough", bd_words);

    n = 0;
    for (c = 0; c < nchan; c++) begin
      sent[c] = 0;
    end
    for (int k = 0; k < chan_words - nchan * ndeser; k++) begin
      c = $urandom % nchan;
      send_word(build_chan_word(c, conf_w'($urandom)), 0);
      sent[c]++;
      n++;
    end
    // complete any half-gathered item so every channel drains
    for (c = 0; c < nchan; c++) begin
      while (sent[c] % ndeser != 0) begin
        send_word(build_chan_word(c, conf_w'($urandom)), 0);
        sent[c]++;
        n++;
      end
    end
    drain_outputs();
    @(negedge clk);
    finish_test("channels", n);

    // each word sits under stall for a few cycles first
    send_word(build_reg_word(5, 16'h5a5a), 6);
    send_word(build_bd_word(6'h2a, 24'h00c0de), 6);
    for (int k = 0; k < ndeser; k++) begin
      send_word(build_chan_word(nchan - 1, conf_w'(16'h1000 + k)), 6);
    end
    drain_outputs();
    @(negedge clk);
    finish_test("stall", stall_words);

    $display("summary: %0d tests run, %0d errors", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
source/pc_config_pkg.sv
source/pc_word_parser.sv
source/conf_chan_deserializer.sv
source/conf_chan_arbiter.sv
source/pc_config_top.sv
test/pc_config_checks.sv
test/pc_config_tb.sv

// File: Bender.yml
package:
  name: pc_config

sources:
  # package first, then the RTL bottom up
  - source/pc_config_pkg.sv
  - source/pc_word_parser.sv
  - source/conf_chan_deserializer.sv
  - source/conf_chan_arbiter.sv
  - source/pc_config_top.sv

  # testbench
  - target: test
    files:
      - test/pc_config_checks.sv
      - test/pc_config_tb.sv
